/* verilog/gpio_pkg.sv */
`default_nettype none

package gpio_pkg;

   // --------------------
   // sizing
   // --------------------

   // pin count ceiling, matches the 16 bit wide bank
   localparam int max_pins = 16;

   // filter divider register width
   localparam int div_width = 8;

   // --------------------
   // register map
   // --------------------

   // word offsets on the 6 bit apb address
   typedef enum logic [5:0]
   {
      addr_dir      = 6'h00, // 1 = output
      addr_out      = 6'h04, // output data
      addr_in       = 6'h08, // filtered input, read only
      addr_int_en   = 6'h0C, // per pin irq enable
      addr_int_pol  = 6'h10, // 1 rising, 0 falling
      addr_int_stat = 6'h14, // write one to clear
      addr_filt_div = 6'h18  // sample tick divider
   } gpio_addr_e;

   // --------------------
   // bus phases
   // --------------------

   // phase seen on the apb port in the last cycle
   typedef enum logic [1:0]
   {
      st_idle,   // psel low
      st_setup,  // psel high, penable low
      st_access  // psel and penable high
   } apb_state_e;

endpackage

`default_nettype wire

/* verilog/gpio_reg_if.sv */
`timescale 1ns/100ps
`default_nettype none

// strobes and data between the apb front end and the register bank
interface gpio_reg_if #(
   parameter int num_pins = 16
);

   logic                rd_stb; // one cycle, setup phase of a read
   logic                wr_stb; // one cycle, access phase of a write
   logic [5:0]          addr;   // byte offset
   logic [num_pins-1:0] wdata;  // low bits of pwdata
   logic [num_pins-1:0] rdata;  // registered read data

   // front end side
   modport bus
   (
      output rd_stb,
      output wr_stb,
      output addr,
      output wdata
   );

   // register bank side
   modport regs
   (
      input  rd_stb,
      input  wr_stb,
      input  addr,
      input  wdata,
      output rdata
   );

endinterface

`default_nettype wire

/* verilog/gpio_apb_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module gpio_apb_fsm (
   input  logic        pclk,    // apb clock
   input  logic        rst_n,   // sync, active low
   input  logic        psel,    // slave select
   input  logic        penable, // access phase
   input  logic        pwrite,  // 1 = write
   input  logic [5:0]  paddr,   // byte address
   input  logic [31:0] pwdata,  // write data
   gpio_reg_if.bus     bus      // strobes to register bank
);

   import gpio_pkg::*;

   apb_state_e state_q;   // phase of previous cycle
   apb_state_e state_nxt; // phase of this cycle

   // --------------------
   // phase tracking
   // --------------------

   always_comb
   begin
      state_nxt = state_q;
      case (state_q)
         st_idle:
            if (psel)
               state_nxt = st_setup; // new transfer
         st_setup:
            if (!psel)
               state_nxt = st_idle;  // master dropped it
            else if (penable)
               state_nxt = st_access;
         st_access:
            if (!psel)
               state_nxt = st_idle;
            else if (!penable)
               state_nxt = st_setup; // back to back transfer
         default:
            state_nxt = st_idle;
      endcase
   end

   always_ff @(posedge pclk)
   begin
      if (!rst_n)
         state_q <= st_idle;
      else
         state_q <= state_nxt;
   end

   // --------------------
   // strobes
   // --------------------

   // read strobe in setup, so the bank can register data for the access cycle
   assign bus.rd_stb = psel && !penable && !pwrite && (state_q != st_setup);
   // write strobe once, in the first access cycle
   assign bus.wr_stb = psel && penable && pwrite && (state_q == st_setup);

   assign bus.addr  = paddr;
   assign bus.wdata = pwdata[$bits(bus.wdata)-1:0]; // unused upper bits dropped

   // access phase only ever follows a setup phase
   a_penable_after_setup : assert property (
      @(posedge pclk) disable iff (!rst_n)
      $rose(penable) |-> (state_q == st_setup)
   );

   // never a read and a write in one cycle
   a_one_strobe : assert property (
      @(posedge pclk) disable iff (!rst_n)
      $onehot0({bus.rd_stb, bus.wr_stb})
   );

endmodule

`default_nettype wire

/* verilog/gpio_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module gpio_regs #(
   parameter int num_pins = 16
) (
   input  logic                           pclk,
   input  logic                           rst_n,
   gpio_reg_if.regs                       rif,              // strobes from front end
   input  logic [num_pins-1:0]            pin_filt,         // filtered pin levels
   input  logic [num_pins-1:0]            tri_state_enable, // forces oe off
   output logic [gpio_pkg::div_width-1:0] filt_div,         // to sample timer
   output logic [num_pins-1:0]            pin_out,
   output logic [num_pins-1:0]            pin_oe_n,         // active low enable
   output logic                           irq
);

   import gpio_pkg::*;

   logic [num_pins-1:0]  dir_q;      // direction, 1 = drive
   logic [num_pins-1:0]  out_q;      // output data
   logic [num_pins-1:0]  int_en_q;   // irq enable
   logic [num_pins-1:0]  int_pol_q;  // edge select
   logic [num_pins-1:0]  int_stat_q; // sticky edge flags
   logic [div_width-1:0] filt_div_q;
   logic [num_pins-1:0]  filt_d_q;   // pin_filt one cycle back
   logic [num_pins-1:0]  rdata_q;    // read data, held until next read

   logic [max_pins-1:0]  wdata_ext;  // write data widened to full bank
   logic [max_pins-1:0]  rd_mux;
   logic [num_pins-1:0]  edge_hit;   // edge of selected polarity
   logic [num_pins-1:0]  stat_clr;   // write one to clear mask

   assign wdata_ext = max_pins'(rif.wdata);

   // --------------------
   // writable registers
   // --------------------

   always_ff @(posedge pclk)
   begin
      if (!rst_n)
      begin
         dir_q      <= '0; // all pins inputs
         out_q      <= '0;
         int_en_q   <= '0;
         int_pol_q  <= '0;
         filt_div_q <= '0;
      end
      else if (rif.wr_stb)
      begin
         case (rif.addr)
            addr_dir      : dir_q      <= rif.wdata;
            addr_out      : out_q      <= rif.wdata;
            addr_int_en   : int_en_q   <= rif.wdata;
            addr_int_pol  : int_pol_q  <= rif.wdata;
            addr_filt_div : filt_div_q <= wdata_ext[div_width-1:0];
            default       : ; // input, status and holes not written here
         endcase
      end
   end

   // --------------------
   // edge detect, status
   // --------------------

   // rising where pol is set, falling where clear
   assign edge_hit = (pin_filt & ~filt_d_q & int_pol_q)
                   | (~pin_filt & filt_d_q & ~int_pol_q);

   assign stat_clr = (rif.wr_stb && (rif.addr == addr_int_stat)) ? rif.wdata : '0;

   always_ff @(posedge pclk)
   begin
      if (!rst_n)
      begin
         filt_d_q   <= '0; // pin_filt also resets low, no false edge
         int_stat_q <= '0;
      end
      else
      begin
         filt_d_q   <= pin_filt;
         int_stat_q <= (int_stat_q & ~stat_clr) | edge_hit; // set beats clear
      end
   end

   // --------------------
   // read path
   // --------------------

   always_comb
   begin
      case (rif.addr)
         addr_dir      : rd_mux = max_pins'(dir_q);
         addr_out      : rd_mux = max_pins'(out_q);
         addr_in       : rd_mux = max_pins'(pin_filt);
         addr_int_en   : rd_mux = max_pins'(int_en_q);
         addr_int_pol  : rd_mux = max_pins'(int_pol_q);
         addr_int_stat : rd_mux = max_pins'(int_stat_q);
         addr_filt_div : rd_mux = max_pins'(filt_div_q);
         default       : rd_mux = '0; // unmapped
      endcase
   end

   // captured at end of setup, valid through access
   always_ff @(posedge pclk)
   begin
      if (!rst_n)
         rdata_q <= '0;
      else if (rif.rd_stb)
         rdata_q <= rd_mux[num_pins-1:0];
   end

   assign rif.rdata = rdata_q;

   // pin side
   assign filt_div = filt_div_q;
   assign pin_out  = out_q;
   assign pin_oe_n = ~dir_q | tri_state_enable;
   assign irq      = |(int_stat_q & int_en_q);

   // irq only from an enabled status bit
   a_irq_source : assert property (
      @(posedge pclk) disable iff (!rst_n)
      irq |-> ((int_stat_q & int_en_q) != '0)
   );

endmodule

`default_nettype wire

/* verilog/gpio_sample_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module gpio_sample_timer (
   input  logic                           pclk,
   input  logic                           rst_n,
   input  logic [gpio_pkg::div_width-1:0] filt_div,   // period minus one
   output logic                           sample_tick // one cycle pulse
);

   import gpio_pkg::*;

   logic [div_width-1:0] cnt_q; // counts down to zero
   logic [div_width-1:0] div_q; // last divider seen
   logic                 div_chg;

   // new divider written, restart the period
   assign div_chg = (filt_div != div_q);

   // --------------------
   // down counter
   // --------------------

   always_ff @(posedge pclk)
   begin
      if (!rst_n)
      begin
         cnt_q <= '0; // divider resets to 0, tick every cycle
         div_q <= '0;
      end
      else
      begin
         div_q <= filt_div;
         if (div_chg || (cnt_q == '0))
            cnt_q <= filt_div; // reload
         else
            cnt_q <= cnt_q - 1'b1;
      end
   end

   assign sample_tick = (cnt_q == '0);

   // back to back ticks only with a zero divider
   a_tick_spacing : assert property (
      @(posedge pclk) disable iff (!rst_n)
      (sample_tick && $past(sample_tick)) |-> ($past(filt_div) == '0)
   );

endmodule

`default_nettype wire

/* verilog/gpio_input_filter.sv */
`timescale 1ns/100ps
`default_nettype none

module gpio_input_filter #(
   parameter int num_pins = 16
) (
   input  logic                pclk,
   input  logic                rst_n,
   input  logic [num_pins-1:0] pin_in,      // async pad levels
   input  logic                sample_tick, // from sample timer
   output logic [num_pins-1:0] pin_filt     // debounced levels
);

   logic [num_pins-1:0] sync1_q; // first metastability stage
   logic [num_pins-1:0] sync2_q; // safe to use
   logic [num_pins-1:0] samp_q;  // level at last tick
   logic [num_pins-1:0] filt_q;
   logic [num_pins-1:0] agree;   // this tick matches the last one
   logic [num_pins-1:0] filt_nxt;

   // --------------------
   // synchronizer
   // --------------------

   always_ff @(posedge pclk)
   begin
      if (!rst_n)
      begin
         sync1_q <= '0;
         sync2_q <= '0;
      end
      else
      begin
         sync1_q <= pin_in;
         sync2_q <= sync1_q;
      end
   end

   // --------------------
   // two sample filter
   // --------------------

   assign agree = ~(sync2_q ^ samp_q);

   // take the new level where two ticks agree, else keep
   assign filt_nxt = (agree & sync2_q) | (~agree & filt_q);

   always_ff @(posedge pclk)
   begin
      if (!rst_n)
      begin
         samp_q <= '0;
         filt_q <= '0;
      end
      else if (sample_tick)
      begin
         samp_q <= sync2_q;
         filt_q <= filt_nxt;
      end
   end

   assign pin_filt = filt_q;

endmodule

`default_nettype wire

/* verilog/gpio_top.sv */
`timescale 1ns/100ps
`default_nettype none

module gpio_top #(
   parameter int num_pins = 16
) (
   input  logic                pclk,
   input  logic                rst_n,
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  logic [5:0]          paddr,
   input  logic [31:0]         pwdata,
   output logic [31:0]         prdata,           // upper bits zero
   input  logic [num_pins-1:0] pin_in,
   input  logic [num_pins-1:0] tri_state_enable, // per pin oe override
   output logic [num_pins-1:0] pin_out,
   output logic [num_pins-1:0] pin_oe_n,
   output logic                irq
);

   import gpio_pkg::*;

   logic [div_width-1:0] filt_div;    // divider register to timer
   logic                 sample_tick; // filter pacing
   logic [num_pins-1:0]  pin_filt;    // filtered levels to bank

   // pin count must fit the bank
   generate
      if ((num_pins < 1) || (num_pins > max_pins))
      begin : g_bad_num_pins
         $error("gpio_top: num_pins out of range");
      end
   endgenerate

   gpio_reg_if #(.num_pins(num_pins)) u_reg_if ();

   // --------------------
   // bus side
   // --------------------

   gpio_apb_fsm u_apb_fsm (
      .pclk    (pclk),
      .rst_n   (rst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .bus     (u_reg_if.bus)
   );

   gpio_regs #(.num_pins(num_pins)) u_regs (
      .pclk             (pclk),
      .rst_n            (rst_n),
      .rif              (u_reg_if.regs),
      .pin_filt         (pin_filt),
      .tri_state_enable (tri_state_enable),
      .filt_div         (filt_div),
      .pin_out          (pin_out),
      .pin_oe_n         (pin_oe_n),
      .irq              (irq)
   );

   assign prdata = 32'(u_reg_if.rdata); // zero padded

   // --------------------
   // pin side
   // --------------------

   gpio_sample_timer u_sample_timer (
      .pclk        (pclk),
      .rst_n       (rst_n),
      .filt_div    (filt_div),
      .sample_tick (sample_tick)
   );

   gpio_input_filter #(.num_pins(num_pins)) u_input_filter (
      .pclk        (pclk),
      .rst_n       (rst_n),
      .pin_in      (pin_in),
      .sample_tick (sample_tick),
      .pin_filt    (pin_filt)
   );

endmodule

`default_nettype wire

/* sim/gpio_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module gpio_tb;

   import gpio_pkg::*;

   localparam int      num_pins     = 16;  // dut default
   localparam realtime clk_period   = 8.0;
   localparam int      reset_cycles = 10;
   localparam int      n_iter       = 12;  // loops per test
   // worst filter latency at the largest divider
   localparam int      max_latency  = 2 + 2 * (2 ** div_width) + 1;
   localparam longint  timeout_cycles = reset_cycles + 200
                                      + 3 * n_iter * (max_latency + 64)
                                      + 2 * n_iter * 64;

   logic                pclk;
   logic                rst_n;
   logic                psel;
   logic                penable;
   logic                pwrite;
   logic [5:0]          paddr;
   logic [31:0]         pwdata;
   logic [31:0]         prdata;
   logic [num_pins-1:0] pin_in;
   logic [num_pins-1:0] tri_state_enable;
   logic [num_pins-1:0] pin_out;
   logic [num_pins-1:0] pin_oe_n;
   logic                irq;

   logic [31:0]         lfsr_q;  // random state

   // --------------------
   // register model
   // --------------------
   logic [num_pins-1:0]  m_dir;
   logic [num_pins-1:0]  m_out;
   logic [num_pins-1:0]  m_en;
   logic [num_pins-1:0]  m_pol;   // 1 rising
   logic [num_pins-1:0]  m_stat;  // accumulated edges
   logic [num_pins-1:0]  m_filt;  // settled input level
   logic [div_width-1:0] m_div;

   gpio_top #(.num_pins(num_pins)) u_gpio_top (
      .pclk             (pclk),
      .rst_n            (rst_n),
      .psel             (psel),
      .penable          (penable),
      .pwrite           (pwrite),
      .paddr            (paddr),
      .pwdata           (pwdata),
      .prdata           (prdata),
      .pin_in           (pin_in),
      .tri_state_enable (tri_state_enable),
      .pin_out          (pin_out),
      .pin_oe_n         (pin_oe_n),
      .irq              (irq)
   );

   always #(clk_period / 2) pclk = ~pclk;

   // right shifting galois form
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      else
         return s >> 1;
   endfunction

   // one lfsr step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v      = {v[30:0], lfsr_q[0]};
         lfsr_q = lfsr_next(lfsr_q);
      end
      return v;
   endfunction

   // sync, two ticks and register plus slack
   function automatic int settle_cycles(input logic [div_width-1:0] div);
      return 2 + 2 * (int'(div) + 1) + 1 + 2;
   endfunction

   // --------------------
   // compare tasks
   // --------------------
   task automatic compare_rdata(input string test, input logic [31:0] exp,
                                input logic [31:0] act);
      if (act !== exp)
      begin
         $display("mismatch %s expected %08h actual %08h", test, exp, act);
         $display("Test failed");
         $fatal(1, "read data wrong");
      end
   endtask

   task automatic compare_pins(input string test, input logic [num_pins-1:0] exp,
                               input logic [num_pins-1:0] act);
      if (act !== exp)
      begin
         $display("mismatch %s expected %04h actual %04h", test, exp, act);
         $display("Test failed");
         $fatal(1, "pin value wrong");
      end
   endtask

   task automatic compare_irq(input string test, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("mismatch %s expected %b actual %b", test, exp, act);
         $display("Test failed");
         $fatal(1, "irq wrong");
      end
   endtask

   // --------------------
   // apb driver
   // --------------------
   // called and returning on a falling edge
   task automatic apb_write(input gpio_addr_e a, input logic [31:0] d);
      @(negedge pclk);
      psel    = 1'b1; // setup
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = a;
      pwdata  = d;
      @(negedge pclk);
      penable = 1'b1; // access
      @(negedge pclk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_read(input gpio_addr_e a, output logic [31:0] d);
      @(negedge pclk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = a;
      @(negedge pclk);
      penable = 1'b1;
      @(negedge pclk);
      psel    = 1'b0;
      penable = 1'b0;
      d       = prdata; // held until next read
   endtask

   task automatic read_check(input gpio_addr_e a, input logic [31:0] exp,
                             input string test);
      logic [31:0] d;
      apb_read(a, d);
      compare_rdata(test, exp, d);
   endtask

   // new stable level, then model the edges it makes
   task automatic apply_pins(input logic [num_pins-1:0] v);
      logic [num_pins-1:0] rise;
      logic [num_pins-1:0] fall;
      pin_in = v;
      repeat (settle_cycles(m_div)) @(negedge pclk);
      rise   = v & ~m_filt;
      fall   = ~v & m_filt;
      m_stat = m_stat | (rise & m_pol) | (fall & ~m_pol);
      m_filt = v;
   endtask

   // --------------------
   // tests
   // --------------------
   task automatic test_reset_readback();
      logic [31:0] d;
      logic [5:0]  hole;
      compare_pins("reset oe_n", '1, pin_oe_n); // all inputs
      compare_irq("reset irq", 1'b0, irq);
      read_check(addr_dir, 32'h0, "reset dir");
      read_check(addr_out, 32'h0, "reset out");
      read_check(addr_in, 32'h0, "reset in");
      read_check(addr_int_en, 32'h0, "reset int_en");
      read_check(addr_int_pol, 32'h0, "reset int_pol");
      read_check(addr_int_stat, 32'h0, "reset int_stat");
      read_check(addr_filt_div, 32'h0, "reset filt_div");
      for (int i = 0; i < n_iter; i++)
      begin
         d = rand_bits(32);
         apb_write(addr_dir, d);
         m_dir = d[num_pins-1:0];
         d = rand_bits(32);
         apb_write(addr_out, d);
         m_out = d[num_pins-1:0];
         d = rand_bits(32);
         apb_write(addr_int_en, d);
         m_en = d[num_pins-1:0];
         d = rand_bits(32);
         apb_write(addr_int_pol, d);
         m_pol = d[num_pins-1:0];
         d = rand_bits(32);
         apb_write(addr_filt_div, d);
         m_div = d[div_width-1:0];
         read_check(addr_dir, 32'(m_dir), "readback dir");
         read_check(addr_out, 32'(m_out), "readback out");
         read_check(addr_int_en, 32'(m_en), "readback int_en");
         read_check(addr_int_pol, 32'(m_pol), "readback int_pol");
         read_check(addr_filt_div, 32'(m_div), "readback filt_div");
         hole = 6'(6'h1c + rand_bits(6) % 36); // 0x1c..0x3f lies past the map
         read_check(gpio_addr_e'(hole), 32'h0, "unmapped");
      end
   endtask

   task automatic test_pin_drive();
      logic [31:0] d;
      for (int i = 0; i < n_iter; i++)
      begin
         d = rand_bits(32);
         apb_write(addr_dir, d);
         m_dir = d[num_pins-1:0];
         d = rand_bits(32);
         tri_state_enable = d[num_pins-1:0]; // still on the falling edge
         d = rand_bits(32);
         apb_write(addr_out, d);
         m_out = d[num_pins-1:0];
         // one cycle after the access phase
         compare_pins("pin drive out", m_out, pin_out);
         compare_pins("pin drive oe_n", ~m_dir | tri_state_enable, pin_oe_n);
      end
   endtask

   task automatic test_input_filter();
      logic [31:0] d;
      for (int i = 0; i < n_iter; i++)
      begin
         d = rand_bits(32);
         apb_write(addr_filt_div, d);
         m_div = d[div_width-1:0];
         d = rand_bits(32);
         apply_pins(d[num_pins-1:0]);
         read_check(addr_in, 32'(m_filt), "input filter");
         read_check(addr_int_stat, 32'(m_stat), "input filter status");
      end
   endtask

   task automatic test_glitch();
      logic [31:0] d;
      int          idx;
      int          len;
      for (int i = 0; i < n_iter; i++)
      begin
         d = rand_bits(4);
         m_div = div_width'(4 + d[3:0]); // at least 4
         apb_write(addr_filt_div, 32'(m_div));
         idx = int'(rand_bits(4) % num_pins);
         len = 1 + int'(rand_bits(8) % 32'(m_div)); // shorter than div+1
         pin_in = m_filt ^ (num_pins'(1) << idx);
         repeat (len) @(negedge pclk);
         pin_in = m_filt;
         repeat (settle_cycles(m_div)) @(negedge pclk);
         read_check(addr_in, 32'(m_filt), "glitch input");
         read_check(addr_int_stat, 32'(m_stat), "glitch status");
      end
   endtask

   task automatic test_interrupts();
      logic [31:0] d;
      for (int i = 0; i < n_iter; i++)
      begin
         d = rand_bits(32);
         apb_write(addr_int_pol, d);
         m_pol = d[num_pins-1:0];
         d = rand_bits(32);
         apb_write(addr_int_en, d);
         m_en = d[num_pins-1:0];
         d = rand_bits(32);
         apply_pins(d[num_pins-1:0]);
         read_check(addr_int_stat, 32'(m_stat), "irq status");
         compare_irq("irq level", |(m_stat & m_en), irq);
         // write one to clear
         d = rand_bits(32);
         apb_write(addr_int_stat, d);
         m_stat = m_stat & ~d[num_pins-1:0];
         compare_irq("irq after clear", |(m_stat & m_en), irq);
         read_check(addr_int_stat, 32'(m_stat), "status clear");
      end
   endtask

   // --------------------
   // main sequence
   // --------------------
   initial
   begin
      pclk             = 1'b0;
      rst_n            = 1'b0;
      psel             = 1'b0;
      penable          = 1'b0;
      pwrite           = 1'b0;
      paddr            = '0;
      pwdata           = '0;
      pin_in           = '0;
      tri_state_enable = '0;
      lfsr_q           = 32'hd52944db;
      m_dir            = '0;
      m_out            = '0;
      m_en             = '0;
      m_pol            = '0;
      m_stat           = '0;
      m_filt           = '0;
      m_div            = '0;
      repeat (reset_cycles) @(negedge pclk);
      rst_n = 1'b1;
      test_reset_readback();
      test_pin_drive();
      test_input_filter();
      test_glitch();
      test_interrupts();
      $display("Test completed successfully");
      $finish;
   end

   // watchdog sized from the worst filter latency
   initial
   begin
      #(timeout_cycles * clk_period);
      $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
      $display("Test failed");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

/* sources.f */
verilog/gpio_pkg.sv
verilog/gpio_reg_if.sv
verilog/gpio_apb_fsm.sv
verilog/gpio_regs.sv
verilog/gpio_sample_timer.sv
verilog/gpio_input_filter.sv
verilog/gpio_top.sv
sim/gpio_tb.sv
